// File: source/wb_params.svh
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// word and product widths
`define WB_DATA_W       32
`define WB_HILO_W       64

// general register file geometry
`define WB_REG_ADDR_W   5
`define WB_NUM_REGS     32

// content of every gpr, hi and lo out of reset
`define WB_RESET_VALUE  32'h0000_0000

// cycles from read strobe to response
`define WB_RD_LATENCY   1

`endif

// File: source/wb_pkg.sv
package wb_pkg;

    // action of one retiring lane
    typedef enum logic [2:0] {
        // lane idle this cycle
        RET_NONE = 3'd0,
        // gpr write at the lane address
        RET_REG  = 3'd1,
        // lane word into hi only
        RET_MTHI = 3'd2,
        // lane word into lo only
        RET_MTLO = 3'd3,
        // mult/div result, upper half to hi, lower half to lo
        RET_HILO = 3'd4,
        // {hi,lo} + product
        RET_MADD = 3'd5,
        // {hi,lo} - product, last legal encoding
        RET_MSUB = 3'd6
    } retire_op_t;

    // source of the registered read port
    typedef enum logic [1:0] {
        SRC_GPR = 2'd0,
        SRC_HI  = 2'd1,
        SRC_LO  = 2'd2
    } read_src_t;

endpackage

// File: source/regfile_bank.sv
`timescale 1ns/1ps

`include "wb_params.svh"

module regfile_bank (
    input  logic                      clk,
    input  logic                      reset,

    // retire lane 0, the younger slot
    input  wb_pkg::retire_op_t        i_op0,
    input  logic [`WB_REG_ADDR_W-1:0] i_wa0,
    input  logic [`WB_DATA_W-1:0]     i_wd0,

    // retire lane 1
    input  wb_pkg::retire_op_t        i_op1,
    input  logic [`WB_REG_ADDR_W-1:0] i_wa1,
    input  logic [`WB_DATA_W-1:0]     i_wd1,

    // forwarded read port
    input  logic [`WB_REG_ADDR_W-1:0] i_rd_addr,
    output logic [`WB_DATA_W-1:0]     o_gpr_data
);

    logic [`WB_DATA_W-1:0] regs [`WB_NUM_REGS];

    logic we0;
    logic we1;
    logic hit0;
    logic hit1;

    // only gpr retires touch the bank, r0 is hardwired
    assign we0 = (i_op0 == wb_pkg::RET_REG) && (i_wa0 != '0);
    assign we1 = (i_op1 == wb_pkg::RET_REG) && (i_wa1 != '0);

    // same-cycle write to the address being read
    assign hit0 = we0 && (i_wa0 == i_rd_addr);
    assign hit1 = we1 && (i_wa1 == i_rd_addr);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `WB_NUM_REGS; i++) begin
                regs[i] <= `WB_RESET_VALUE;
            end
        end else begin
            // lane 1 first so lane 0 lands last on a shared address
            if (we1) begin
                regs[i_wa1] <= i_wd1;
            end
            if (we0) begin
                regs[i_wa0] <= i_wd0;
            end
        end
    end

    // forward retiring data, lane 0 ahead of lane 1
    always_comb begin
        if (hit0) begin
            o_gpr_data = i_wd0;
        end else if (hit1) begin
            o_gpr_data = i_wd1;
        end else begin
            o_gpr_data = regs[i_rd_addr];
        end
    end

    // r0 never leaves its reset value, whatever the lanes retire
    a_reg0_zero: assert property (
        @(posedge clk) disable iff (reset)
        regs[0] == `WB_RESET_VALUE
    ) else $error("regfile_bank: register 0 holds %h", regs[0]);

endmodule

// File: source/hilo_unit.sv
`timescale 1ns/1ps

`include "wb_params.svh"

module hilo_unit (
    input  logic                   clk,
    input  logic                   reset,

    // retire lane 0, the younger slot
    input  wb_pkg::retire_op_t     i_op0,
    input  logic [`WB_DATA_W-1:0]  i_wd0,
    input  logic [`WB_HILO_W-1:0]  i_prod0,

    // retire lane 1
    input  wb_pkg::retire_op_t     i_op1,
    input  logic [`WB_DATA_W-1:0]  i_wd1,
    input  logic [`WB_HILO_W-1:0]  i_prod1,

    // forwarded next values
    output logic [`WB_DATA_W-1:0]  o_hi,
    output logic [`WB_DATA_W-1:0]  o_lo
);

    logic [`WB_DATA_W-1:0]  hi_q;
    logic [`WB_DATA_W-1:0]  lo_q;
    logic [`WB_HILO_W-1:0]  stored_pair;

    // per-lane views, index is the lane number
    wb_pkg::retire_op_t     lane_op   [2];
    logic [`WB_DATA_W-1:0]  lane_wd   [2];
    logic [`WB_HILO_W-1:0]  lane_prod [2];
    logic [`WB_DATA_W-1:0]  hi_cand   [2];
    logic [`WB_DATA_W-1:0]  lo_cand   [2];
    logic [1:0]             hi_we;
    logic [1:0]             lo_we;

    logic [`WB_DATA_W-1:0]  hi_next;
    logic [`WB_DATA_W-1:0]  lo_next;

    assign lane_op[0]   = i_op0;
    assign lane_op[1]   = i_op1;
    assign lane_wd[0]   = i_wd0;
    assign lane_wd[1]   = i_wd1;
    assign lane_prod[0] = i_prod0;
    assign lane_prod[1] = i_prod1;

    // both lanes accumulate on the pair held before this cycle
    assign stored_pair = {hi_q, lo_q};

    // candidates and half enables of each lane
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            hi_we[i]   = 1'b0;
            lo_we[i]   = 1'b0;
            hi_cand[i] = lane_prod[i][`WB_HILO_W-1:`WB_DATA_W];
            lo_cand[i] = lane_prod[i][`WB_DATA_W-1:0];
            case (lane_op[i])
                wb_pkg::RET_MTHI: begin
                    hi_we[i]   = 1'b1;
                    hi_cand[i] = lane_wd[i];
                end
                wb_pkg::RET_MTLO: begin
                    lo_we[i]   = 1'b1;
                    lo_cand[i] = lane_wd[i];
                end
                wb_pkg::RET_HILO: begin
                    hi_we[i] = 1'b1;
                    lo_we[i] = 1'b1;
                end
                wb_pkg::RET_MADD: begin
                    hi_we[i] = 1'b1;
                    lo_we[i] = 1'b1;
                    {hi_cand[i], lo_cand[i]} = stored_pair + lane_prod[i];
                end
                wb_pkg::RET_MSUB: begin
                    hi_we[i] = 1'b1;
                    lo_we[i] = 1'b1;
                    {hi_cand[i], lo_cand[i]} = stored_pair - lane_prod[i];
                end
                default: begin
                end
            endcase
        end
    end

    // lane 1 applied first, lane 0 overrides per half
    always_comb begin
        hi_next = hi_q;
        lo_next = lo_q;
        for (int i = 1; i >= 0; i--) begin
            if (hi_we[i]) begin
                hi_next = hi_cand[i];
            end
            if (lo_we[i]) begin
                lo_next = lo_cand[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= `WB_RESET_VALUE;
            lo_q <= `WB_RESET_VALUE;
        end else begin
            hi_q <= hi_next;
            lo_q <= lo_next;
        end
    end

    assign o_hi = hi_next;
    assign o_lo = lo_next;

    // msub is the highest encoding, anything above is a corrupt retire
    a_legal_op: assert property (
        @(posedge clk) disable iff (reset)
        (i_op0 <= wb_pkg::RET_MSUB) && (i_op1 <= wb_pkg::RET_MSUB)
    ) else $error("hilo_unit: illegal retire op %0d / %0d", i_op0, i_op1);

endmodule

// File: source/operand_read.sv
`timescale 1ns/1ps

`include "wb_params.svh"

module operand_read (
    input  logic                   clk,
    input  logic                   reset,

    // single-cycle read strobe
    input  logic                   i_rd_en,
    input  wb_pkg::read_src_t      i_rd_src,

    // forwarded words from the bank and hi/lo
    input  logic [`WB_DATA_W-1:0]  i_gpr_data,
    input  logic [`WB_DATA_W-1:0]  i_hi,
    input  logic [`WB_DATA_W-1:0]  i_lo,

    // registered response
    output logic                   o_rd_valid,
    output logic [`WB_DATA_W-1:0]  o_rd_data
);

    logic [`WB_DATA_W-1:0] sel_data;

    // unused encoding falls back to the gpr
    always_comb begin
        case (i_rd_src)
            wb_pkg::SRC_HI: begin
                sel_data = i_hi;
            end
            wb_pkg::SRC_LO: begin
                sel_data = i_lo;
            end
            default: begin
                sel_data = i_gpr_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_rd_valid <= 1'b0;
        end else begin
            o_rd_valid <= i_rd_en;
        end
    end

    // data holds between responses
    always_ff @(posedge clk) begin
        if (reset) begin
            o_rd_data <= `WB_RESET_VALUE;
        end else if (i_rd_en) begin
            o_rd_data <= sel_data;
        end
    end

    // one response per strobe at the fixed latency
    a_rd_resp: assert property (
        @(posedge clk) disable iff (reset)
        i_rd_en |-> ##`WB_RD_LATENCY o_rd_valid
    ) else $error("operand_read: strobe without response");

endmodule

// File: source/writeback_core.sv
`timescale 1ns/1ps

`include "wb_params.svh"

module writeback_core (
    input  logic                      clk,
    input  logic                      reset,

    // retire lane 0, wins on a shared target
    input  wb_pkg::retire_op_t        i_op0,
    input  logic [`WB_REG_ADDR_W-1:0] i_wa0,
    input  logic [`WB_DATA_W-1:0]     i_wd0,
    input  logic [`WB_HILO_W-1:0]     i_prod0,

    // retire lane 1
    input  wb_pkg::retire_op_t        i_op1,
    input  logic [`WB_REG_ADDR_W-1:0] i_wa1,
    input  logic [`WB_DATA_W-1:0]     i_wd1,
    input  logic [`WB_HILO_W-1:0]     i_prod1,

    // read request
    input  logic                      i_rd_en,
    input  wb_pkg::read_src_t         i_rd_src,
    input  logic [`WB_REG_ADDR_W-1:0] i_rd_addr,

    // read response
    output logic                      o_rd_valid,
    output logic [`WB_DATA_W-1:0]     o_rd_data
);

    logic [`WB_DATA_W-1:0] gpr_data;
    logic [`WB_DATA_W-1:0] hi_data;
    logic [`WB_DATA_W-1:0] lo_data;

    // general registers, gpr retires only
    regfile_bank u_regfile_bank (
        .clk        (clk),
        .reset      (reset),
        .i_op0      (i_op0),
        .i_wa0      (i_wa0),
        .i_wd0      (i_wd0),
        .i_op1      (i_op1),
        .i_wa1      (i_wa1),
        .i_wd1      (i_wd1),
        .i_rd_addr  (i_rd_addr),
        .o_gpr_data (gpr_data)
    );

    // hi/lo moves, products and accumulates
    hilo_unit u_hilo_unit (
        .clk     (clk),
        .reset   (reset),
        .i_op0   (i_op0),
        .i_wd0   (i_wd0),
        .i_prod0 (i_prod0),
        .i_op1   (i_op1),
        .i_wd1   (i_wd1),
        .i_prod1 (i_prod1),
        .o_hi    (hi_data),
        .o_lo    (lo_data)
    );

    operand_read u_operand_read (
        .clk        (clk),
        .reset      (reset),
        .i_rd_en    (i_rd_en),
        .i_rd_src   (i_rd_src),
        .i_gpr_data (gpr_data),
        .i_hi       (hi_data),
        .i_lo       (lo_data),
        .o_rd_valid (o_rd_valid),
        .o_rd_data  (o_rd_data)
    );

endmodule

// File: test/writeback_core_tb.sv
`timescale 1ns/1ps

`include "wb_params.svh"

module writeback_core_tb;

    localparam int RESP_TIMEOUT = 20;
    localparam int NUM_RANDOM   = 32;

    // one table row, both lanes plus the read request
    typedef struct packed {
        wb_pkg::retire_op_t        op0;
        logic [`WB_REG_ADDR_W-1:0] wa0;
        logic [`WB_DATA_W-1:0]     wd0;
        logic [`WB_HILO_W-1:0]     prod0;
        wb_pkg::retire_op_t        op1;
        logic [`WB_REG_ADDR_W-1:0] wa1;
        logic [`WB_DATA_W-1:0]     wd1;
        logic [`WB_HILO_W-1:0]     prod1;
        wb_pkg::read_src_t         src;
        logic [`WB_REG_ADDR_W-1:0] addr;
        logic [`WB_DATA_W-1:0]     expected;
    } entry_t;

    logic                      clk;
    logic                      reset;
    wb_pkg::retire_op_t        i_op0;
    logic [`WB_REG_ADDR_W-1:0] i_wa0;
    logic [`WB_DATA_W-1:0]     i_wd0;
    logic [`WB_HILO_W-1:0]     i_prod0;
    wb_pkg::retire_op_t        i_op1;
    logic [`WB_REG_ADDR_W-1:0] i_wa1;
    logic [`WB_DATA_W-1:0]     i_wd1;
    logic [`WB_HILO_W-1:0]     i_prod1;
    logic                      i_rd_en;
    wb_pkg::read_src_t         i_rd_src;
    logic [`WB_REG_ADDR_W-1:0] i_rd_addr;
    logic                      o_rd_valid;
    logic [`WB_DATA_W-1:0]     o_rd_data;

    entry_t table_q [$];
    string  name_q  [$];

    // reference state
    logic [`WB_DATA_W-1:0] model_regs [`WB_NUM_REGS];
    logic [`WB_DATA_W-1:0] model_hi;
    logic [`WB_DATA_W-1:0] model_lo;

    logic [15:0] lfsr;
    int          errors;
    int          checks;

    writeback_core DUT (
        .clk        (clk),
        .reset      (reset),
        .i_op0      (i_op0),
        .i_wa0      (i_wa0),
        .i_wd0      (i_wd0),
        .i_prod0    (i_prod0),
        .i_op1      (i_op1),
        .i_wa1      (i_wa1),
        .i_wd1      (i_wd1),
        .i_prod1    (i_prod1),
        .i_rd_en    (i_rd_en),
        .i_rd_src   (i_rd_src),
        .i_rd_addr  (i_rd_addr),
        .o_rd_valid (o_rd_valid),
        .o_rd_data  (o_rd_data)
    );

    always #2 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] value;
        value = 64'd0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[62:0], lfsr[0]};
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // one lane's effect on hi/lo, accumulates see the pair from before the cycle
    function automatic void hilo_lane(input wb_pkg::retire_op_t op,
                                      input logic [31:0] wd, input logic [63:0] prod,
                                      input logic [63:0] old_pair,
                                      inout logic [31:0] hi, inout logic [31:0] lo);
        logic [63:0] acc;
        acc = 64'd0;
        case (op)
            wb_pkg::RET_MTHI: begin
                hi = wd;
            end
            wb_pkg::RET_MTLO: begin
                lo = wd;
            end
            wb_pkg::RET_HILO: begin
                hi = prod[63:32];
                lo = prod[31:0];
            end
            wb_pkg::RET_MADD: begin
                acc = old_pair + prod;
                hi  = acc[63:32];
                lo  = acc[31:0];
            end
            wb_pkg::RET_MSUB: begin
                acc = old_pair - prod;
                hi  = acc[63:32];
                lo  = acc[31:0];
            end
            default: begin
            end
        endcase
    endfunction

    // advance the model by one row and return the word the read should see
    function automatic logic [31:0] model_step(input entry_t e);
        logic [63:0] old_pair;
        logic [31:0] new_hi;
        logic [31:0] new_lo;
        logic [31:0] result;
        old_pair = {model_hi, model_lo};
        new_hi   = model_hi;
        new_lo   = model_lo;
        // lane 1 is older, lane 0 lands on top
        hilo_lane(e.op1, e.wd1, e.prod1, old_pair, new_hi, new_lo);
        hilo_lane(e.op0, e.wd0, e.prod0, old_pair, new_hi, new_lo);
        model_hi = new_hi;
        model_lo = new_lo;
        if (e.op1 == wb_pkg::RET_REG && e.wa1 != 0) begin
            model_regs[e.wa1] = e.wd1;
        end
        if (e.op0 == wb_pkg::RET_REG && e.wa0 != 0) begin
            model_regs[e.wa0] = e.wd0;
        end
        case (e.src)
            wb_pkg::SRC_HI: result = model_hi;
            wb_pkg::SRC_LO: result = model_lo;
            default:        result = model_regs[e.addr];
        endcase
        return result;
    endfunction

    task automatic add_entry(input string name,
                             input wb_pkg::retire_op_t op0, input logic [4:0] wa0,
                             input logic [31:0] wd0, input logic [63:0] prod0,
                             input wb_pkg::retire_op_t op1, input logic [4:0] wa1,
                             input logic [31:0] wd1, input logic [63:0] prod1,
                             input wb_pkg::read_src_t src, input logic [4:0] addr,
                             input logic [31:0] expected);
        table_q.push_back('{op0, wa0, wd0, prod0, op1, wa1, wd1, prod1, src, addr, expected});
        name_q.push_back(name);
    endtask

    task automatic build_directed();
        // reset contents and the hardwired r0
        add_entry("reset_r5", wb_pkg::RET_NONE, 0, 0, 0,
                  wb_pkg::RET_NONE, 0, 0, 0, wb_pkg::SRC_GPR, 5, 32'h0);
        add_entry("reset_hi", wb_pkg::RET_NONE, 0, 0, 0,
                  wb_pkg::RET_NONE, 0, 0, 0, wb_pkg::SRC_HI, 0, 32'h0);
        add_entry("reset_lo", wb_pkg::RET_NONE, 0, 0, 0,
                  wb_pkg::RET_NONE, 0, 0, 0, wb_pkg::SRC_LO, 0, 32'h0);
        add_entry("r0_write", wb_pkg::RET_REG, 0, 32'hdead_beef, 0,
                  wb_pkg::RET_NONE, 0, 0, 0, wb_pkg::SRC_GPR, 0, 32'h0);
        // gpr writes and same-cycle forwarding
        add_entry("two_lanes_fwd", wb_pkg::RET_REG, 3, 32'h1111_1111, 0,
                  wb_pkg::RET_REG, 4, 32'h2222_2222, 0, wb_pkg::SRC_GPR, 3, 32'h1111_1111);
        add_entry("read_r4", wb_pkg::RET_NONE, 0, 0, 0,
                  wb_pkg::RET_NONE, 0, 0, 0, wb_pkg::SRC_GPR, 4, 32'h2222_2222);
        add_entry("lane1_fwd_r7", wb_pkg::RET_NONE, 0, 0, 0,
                  wb_pkg::RET_REG, 7, 32'ha5a5_0007, 0, wb_pkg::SRC_GPR, 7, 32'ha5a5_0007);
        // lane 0 wins on a shared target
        add_entry("same_reg", wb_pkg::RET_REG, 9, 32'h0000_0900, 0,
                  wb_pkg::RET_REG, 9, 32'h0000_0901, 0, wb_pkg::SRC_GPR, 9, 32'h0000_0900);
        add_entry("same_reg_stored", wb_pkg::RET_NONE, 0, 0, 0,
                  wb_pkg::RET_NONE, 0, 0, 0, wb_pkg::SRC_GPR, 9, 32'h0000_0900);
        add_entry("both_mthi", wb_pkg::RET_MTHI, 0, 32'h0000_00a0, 0,
                  wb_pkg::RET_MTHI, 0, 32'h0000_00a1, 0, wb_pkg::SRC_HI, 0, 32'h0000_00a0);
        // product split and mtlo
        add_entry("hilo_hi", wb_pkg::RET_HILO, 0, 0, 64'h0123_4567_89ab_cdef,
                  wb_pkg::RET_NONE, 0, 0, 0, wb_pkg::SRC_HI, 0, 32'h0123_4567);
        add_entry("hilo_lo", wb_pkg::RET_NONE, 0, 0, 0,
                  wb_pkg::RET_NONE, 0, 0, 0, wb_pkg::SRC_LO, 0, 32'h89ab_cdef);
        add_entry("mtlo", wb_pkg::RET_NONE, 0, 0, 0,
                  wb_pkg::RET_MTLO, 0, 32'h5555_aaaa, 0, wb_pkg::SRC_LO, 0, 32'h5555_aaaa);
        add_entry("mtlo_hi_kept", wb_pkg::RET_NONE, 0, 0, 0,
                  wb_pkg::RET_NONE, 0, 0, 0, wb_pkg::SRC_HI, 0, 32'h0123_4567);
        // carry out of lo, then borrow back into it
        add_entry("madd_carry", wb_pkg::RET_MADD, 0, 0, 64'h0000_0000_aaaa_5556,
                  wb_pkg::RET_NONE, 0, 0, 0, wb_pkg::SRC_HI, 0, 32'h0123_4568);
        add_entry("madd_lo", wb_pkg::RET_NONE, 0, 0, 0,
                  wb_pkg::RET_NONE, 0, 0, 0, wb_pkg::SRC_LO, 0, 32'h0000_0000);
        add_entry("msub_borrow", wb_pkg::RET_MSUB, 0, 0, 64'h1,
                  wb_pkg::RET_NONE, 0, 0, 0, wb_pkg::SRC_LO, 0, 32'hffff_ffff);
        add_entry("msub_hi", wb_pkg::RET_NONE, 0, 0, 0,
                  wb_pkg::RET_NONE, 0, 0, 0, wb_pkg::SRC_HI, 0, 32'h0123_4567);
        // both lanes accumulate, lane 0 result from the stored pair
        add_entry("madd_both_lo", wb_pkg::RET_MADD, 0, 0, 64'h10,
                  wb_pkg::RET_MADD, 0, 0, 64'h1000_0000_0000_0000,
                  wb_pkg::SRC_LO, 0, 32'h0000_000f);
        add_entry("madd_both_hi", wb_pkg::RET_NONE, 0, 0, 0,
                  wb_pkg::RET_NONE, 0, 0, 0, wb_pkg::SRC_HI, 0, 32'h0123_4568);
    endtask

    task automatic build_random();
        entry_t      e;
        logic [2:0]  op_bits;
        logic [1:0]  src_bits;
        logic [31:0] unused;
        int          n;
        for (int i = 0; i < `WB_NUM_REGS; i++) begin
            model_regs[i] = `WB_RESET_VALUE;
        end
        model_hi = `WB_RESET_VALUE;
        model_lo = `WB_RESET_VALUE;
        // bring the model up to the end of the directed rows
        n = table_q.size();
        for (int k = 0; k < n; k++) begin
            unused = model_step(table_q[k]);
        end
        for (int k = 0; k < NUM_RANDOM; k++) begin
            op_bits = 3'(rand_bits(3));
            // code 7 is not an op, fold it onto a gpr write
            if (op_bits == 3'd7) begin
                op_bits = 3'd1;
            end
            e.op0   = wb_pkg::retire_op_t'(op_bits);
            e.wa0   = 5'(rand_bits(3));
            e.wd0   = 32'(rand_bits(32));
            e.prod0 = rand_bits(64);
            op_bits = 3'(rand_bits(3));
            if (op_bits == 3'd7) begin
                op_bits = 3'd1;
            end
            e.op1   = wb_pkg::retire_op_t'(op_bits);
            e.wa1   = 5'(rand_bits(3));
            e.wd1   = 32'(rand_bits(32));
            e.prod1 = rand_bits(64);
            src_bits = 2'(rand_bits(2));
            if (src_bits == 2'd3) begin
                src_bits = 2'd0;
            end
            e.src      = wb_pkg::read_src_t'(src_bits);
            e.addr     = 5'(rand_bits(3));
            e.expected = model_step(e);
            table_q.push_back(e);
            name_q.push_back($sformatf("rand_%0d", k));
        end
    endtask

    task automatic drive_idle();
        i_op0     = wb_pkg::RET_NONE;
        i_wa0     = '0;
        i_wd0     = '0;
        i_prod0   = '0;
        i_op1     = wb_pkg::RET_NONE;
        i_wa1     = '0;
        i_wd1     = '0;
        i_prod1   = '0;
        i_rd_en   = 1'b0;
        i_rd_src  = wb_pkg::SRC_GPR;
        i_rd_addr = '0;
    endtask

    task automatic apply_entry(input int idx);
        entry_t e;
        int     waited;
        e = table_q[idx];
        @(negedge clk);
        // previous response must already be gone
        check_value({name_q[idx], " idle"}, 32'd0, {31'd0, o_rd_valid});
        i_op0     = e.op0;
        i_wa0     = e.wa0;
        i_wd0     = e.wd0;
        i_prod0   = e.prod0;
        i_op1     = e.op1;
        i_wa1     = e.wa1;
        i_wd1     = e.wd1;
        i_prod1   = e.prod1;
        i_rd_src  = e.src;
        i_rd_addr = e.addr;
        i_rd_en   = 1'b1;
        @(negedge clk);
        drive_idle();
        waited = 1;
        while (!o_rd_valid && waited < RESP_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!o_rd_valid) begin
            errors++;
            $display("Error: %s read response never arrived within %0d cycles",
                     name_q[idx], RESP_TIMEOUT);
        end else begin
            check_value({name_q[idx], " latency"}, 32'd1, waited);
            check_value(name_q[idx], e.expected, o_rd_data);
        end
    endtask

    initial begin
        clk    = 1'b0;
        reset  = 1'b1;
        errors = 0;
        checks = 0;
        lfsr   = 16'd29071;
        drive_idle();
        build_directed();
        build_random();
        repeat (3) @(negedge clk);
        reset = 1'b0;
        for (int k = 0; k < table_q.size(); k++) begin
            apply_entry(k);
        end
        @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: writeback_core.f
+incdir+source
source/wb_pkg.sv
source/regfile_bank.sv
source/hilo_unit.sv
source/operand_read.sv
source/writeback_core.sv
test/writeback_core_tb.sv
